// File: shift_engine_defines.svh
// Sizes and APB register map for the shift coprocessor, included by the RTL and the testbench
`ifndef SHIFT_ENGINE_DEFINES_SVH
`define SHIFT_ENGINE_DEFINES_SVH

// Datapath sizes
`define SE_DATA_W     16      // One buffer word
`define SE_ADDR_W     4       // 16 words in the buffer
`define SE_CNT_W      5       // Holds 0 to 16

// APB byte addresses
`define SE_REG_CTRL0  8'h00   // Channel 0 command
`define SE_REG_CTRL1  8'h04   // Channel 1 command
`define SE_REG_STATUS 8'h08   // Busy bits and ones counts
`define SE_BUF_BASE   8'h40   // Buffer window, 0x40 to 0x7C

`endif

// File: shift_engine_pkg.sv
// Shared enums of the shift coprocessor, imported by the RTL and the testbench
package shift_engine_pkg;

    // Shifter select, same encoding as the shift register control pins
    typedef enum logic [1:0] {
        SEL_HOLD  = 2'b00,
        SEL_RIGHT = 2'b01,
        SEL_LEFT  = 2'b10,
        SEL_LOAD  = 2'b11
    } shift_sel_e;

    // Command opcode in CTRL[1:0]
    typedef enum logic [1:0] {
        OP_SHL = 2'b00,  // Shift left, fill enters at bit 0
        OP_SHR = 2'b01,  // Shift right, fill enters at MSB
        OP_ROL = 2'b10,
        OP_ROR = 2'b11
    } shift_op_e;

    // Channel sequencer
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,   // Read request out to the buffer
        ST_LOAD,    // Read data valid, load shifter
        ST_SHIFT,   // One bit per cycle, then one drain cycle
        ST_STORE    // Write request back to the buffer
    } chan_state_e;

endpackage

// File: shifter_universal.sv
// Universal shift register with hold, right, left and load; used by each shift channel
`timescale 1ns/1ps
`include "shift_engine_defines.svh"

module shifter_universal #(
    parameter int WIDTH = `SE_DATA_W
) (
    input  logic                         clk,
    input  logic                         i_reset,
    input  shift_engine_pkg::shift_sel_e i_select,    // Hold, right, left, load
    input  logic [WIDTH-1:0]             i_pdata,     // Parallel load value
    input  logic                         i_sdata_lt,  // Enters bit 0 on a left shift
    input  logic                         i_sdata_rt,  // Enters MSB on a right shift
    output logic [WIDTH-1:0]             o_pdata,
    output logic                         o_sdata_lt,  // MSB that left on the last left shift
    output logic                         o_sdata_rt   // LSB that left on the last right shift
);
    import shift_engine_pkg::*;

    logic [WIDTH-1:0] pdata_nxt;
    logic             sdata_lt_nxt;
    logic             sdata_rt_nxt;

    always_comb begin
        pdata_nxt    = o_pdata;   // Hold by default
        sdata_lt_nxt = 1'b0;      // Nothing leaves unless shifting
        sdata_rt_nxt = 1'b0;
        case (i_select)
            SEL_RIGHT: begin
                pdata_nxt    = {i_sdata_rt, o_pdata[WIDTH-1:1]};
                sdata_rt_nxt = o_pdata[0];
            end
            SEL_LEFT: begin
                pdata_nxt    = {o_pdata[WIDTH-2:0], i_sdata_lt};
                sdata_lt_nxt = o_pdata[WIDTH-1];
            end
            SEL_LOAD: pdata_nxt = i_pdata;
            default:  pdata_nxt = o_pdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pdata    <= '0;
            o_sdata_lt <= 1'b0;
            o_sdata_rt <= 1'b0;
        end else begin
            o_pdata    <= pdata_nxt;
            o_sdata_lt <= sdata_lt_nxt;   // Serial out lags the shift by one cycle
            o_sdata_rt <= sdata_rt_nxt;
        end
    end

    // Select driven from a live FSM once out of reset
    a_select_known: assert property (@(posedge clk) disable iff (i_reset)
        !$isunknown(i_select));

endmodule

// File: shift_channel.sv
// Per-channel sequencer that fetches a word, shifts or rotates it and stores it back
`timescale 1ns/1ps
`include "shift_engine_defines.svh"

module shift_channel (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_start,     // One-cycle pulse from the APB slave
    input  shift_engine_pkg::shift_op_e i_op,
    input  logic                        i_fill,
    input  logic [`SE_CNT_W-1:0]        i_count,
    input  logic [`SE_ADDR_W-1:0]       i_addr,
    output logic                        o_busy,
    output logic [`SE_CNT_W-1:0]        o_ones,      // Ones shifted out so far
    output logic                        o_buf_req,
    output logic                        o_buf_we,
    output logic [`SE_ADDR_W-1:0]       o_buf_addr,
    output logic [`SE_DATA_W-1:0]       o_buf_wdata,
    input  logic                        i_buf_gnt,
    input  logic [`SE_DATA_W-1:0]       i_buf_rdata  // Valid the cycle after a read grant
);
    import shift_engine_pkg::*;

    chan_state_e            state_q;
    shift_op_e              op_q;
    logic                   fill_q;
    logic [`SE_CNT_W-1:0]   left_q;     // Shifts still to do
    logic [`SE_ADDR_W-1:0]  addr_q;
    shift_sel_e             sel;
    logic [`SE_DATA_W-1:0]  sh_data;
    logic                   sh_out_lt;
    logic                   sh_out_rt;
    logic                   sin_lt;
    logic                   sin_rt;

    // Sequencer
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= ST_IDLE;
            o_ones  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        state_q <= ST_FETCH;
                        o_ones  <= '0;    // Fresh count per command
                    end
                end
                ST_FETCH: begin
                    if (i_buf_gnt) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD:  state_q <= ST_SHIFT;
                ST_SHIFT: begin
                    // Serial out holds the bit from the previous cycle's shift
                    o_ones <= o_ones + {{(`SE_CNT_W-1){1'b0}}, sh_out_lt | sh_out_rt};
                    if (left_q == '0) begin
                        state_q <= ST_STORE;  // This was the drain cycle
                    end
                end
                ST_STORE: begin
                    if (i_buf_gnt) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command fields and shift counter
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_start) begin
            op_q   <= i_op;
            fill_q <= i_fill;
            left_q <= i_count;
            addr_q <= i_addr;
        end else if (state_q == ST_SHIFT && left_q != '0) begin
            left_q <= left_q - 1'b1;
        end
    end

    // Shifter control
    always_comb begin
        sel = SEL_HOLD;
        if (state_q == ST_LOAD) begin
            sel = SEL_LOAD;
        end else if (state_q == ST_SHIFT && left_q != '0) begin
            if (op_q == OP_SHL || op_q == OP_ROL) begin
                sel = SEL_LEFT;
            end else begin
                sel = SEL_RIGHT;
            end
        end
    end

    // Rotates recirculate the outgoing end bit to the opposite side
    assign sin_lt = (op_q == OP_ROL) ? sh_data[`SE_DATA_W-1] : fill_q;
    assign sin_rt = (op_q == OP_ROR) ? sh_data[0] : fill_q;

    shifter_universal #(
        .WIDTH      (`SE_DATA_W)
    ) u_shifter (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_select   (sel),
        .i_pdata    (i_buf_rdata),
        .i_sdata_lt (sin_lt),
        .i_sdata_rt (sin_rt),
        .o_pdata    (sh_data),
        .o_sdata_lt (sh_out_lt),
        .o_sdata_rt (sh_out_rt)
    );

    assign o_busy      = (state_q != ST_IDLE);
    assign o_buf_req   = (state_q == ST_FETCH) || (state_q == ST_STORE);
    assign o_buf_we    = (state_q == ST_STORE);
    assign o_buf_addr  = addr_q;
    assign o_buf_wdata = sh_data;   // Result straight from the shifter

    // Request and address stay put until the buffer grants
    a_req_held: assert property (@(posedge clk) disable iff (i_reset)
        (o_buf_req && !i_buf_gnt) |=> (o_buf_req && $stable(o_buf_addr)));

endmodule

// File: word_buffer_arb.sv
// 16-word buffer RAM shared by channel 0, channel 1 and APB through a round-robin arbiter
`timescale 1ns/1ps
`include "shift_engine_defines.svh"

module word_buffer_arb (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic [2:0]            i_req,        // 0 and 1 are channels, 2 is APB
    input  logic [2:0]            i_we,
    input  logic [`SE_ADDR_W-1:0] i_addr [3],
    input  logic [`SE_DATA_W-1:0] i_wdata [3],
    output logic [2:0]            o_gnt,        // Same cycle as the request
    output logic [`SE_DATA_W-1:0] o_rdata       // Shared read data valid the cycle after grant
);
    logic [`SE_DATA_W-1:0] mem [1 << `SE_ADDR_W];
    logic [1:0]            last_q;   // Last client granted gets lowest priority next
    logic [1:0]            win;

    // Scan from last+3 down to last+1 so the nearest requester wins
    always_comb begin
        int idx;
        o_gnt = 3'b000;
        win   = last_q;
        for (int k = 3; k >= 1; k--) begin
            idx = (int'(last_q) + k) % 3;
            if (i_req[idx]) begin
                o_gnt      = 3'b000;
                o_gnt[idx] = 1'b1;
                win        = idx[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            last_q <= 2'd2;   // Channel 0 first after reset
        end else if (|o_gnt) begin
            last_q <= win;
        end
    end

    // Single port used by the winner only
    always_ff @(posedge clk) begin
        if (|o_gnt) begin
            if (i_we[win]) begin
                mem[i_addr[win]] <= i_wdata[win];
            end
            o_rdata <= mem[i_addr[win]];   // Stale on a write and ignored
        end
    end

    // Round robin passes the grant on whenever another client waits
    a_gnt_rr: assert property (@(posedge clk) disable iff (i_reset)
        ((o_gnt & $past(o_gnt)) != 3'b000) |-> ((i_req & ~o_gnt) == 3'b000));

endmodule

// File: apb_shift_regs.sv
// APB slave of the shift coprocessor: command registers, STATUS and the buffer window
`timescale 1ns/1ps
`include "shift_engine_defines.svh"

module apb_shift_regs (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [7:0]                  i_paddr,
    input  logic [31:0]                 i_pwdata,
    output logic [31:0]                 o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output logic [1:0]                  o_start,   // Registered, fields valid alongside
    output shift_engine_pkg::shift_op_e o_op0,
    output logic                        o_fill0,
    output logic [`SE_CNT_W-1:0]        o_count0,
    output logic [`SE_ADDR_W-1:0]       o_addr0,
    output shift_engine_pkg::shift_op_e o_op1,
    output logic                        o_fill1,
    output logic [`SE_CNT_W-1:0]        o_count1,
    output logic [`SE_ADDR_W-1:0]       o_addr1,
    input  logic [1:0]                  i_busy,
    input  logic [`SE_CNT_W-1:0]        i_ones0,
    input  logic [`SE_CNT_W-1:0]        i_ones1,
    output logic                        o_buf_req,
    output logic                        o_buf_we,
    output logic [`SE_ADDR_W-1:0]       o_buf_addr,
    output logic [`SE_DATA_W-1:0]       o_buf_wdata,
    input  logic                        i_buf_gnt,
    input  logic [`SE_DATA_W-1:0]       i_buf_rdata
);
    import shift_engine_pkg::*;

    logic                  access;     // APB access phase
    logic                  is_buf;
    logic [1:0]            ctrl_hit;
    logic [1:0]            busy_eff;   // Channel busy or start in flight
    logic [1:0]            wr_ok;
    logic                  rd_q;       // Buffer read data arrives this cycle
    shift_op_e             op_q    [2];
    logic                  fill_q  [2];
    logic [`SE_CNT_W-1:0]  count_q [2];
    logic [`SE_ADDR_W-1:0] addr_q  [2];

    assign access   = i_psel & i_penable;
    assign is_buf   = (i_paddr & 8'hC0) == `SE_BUF_BASE;
    assign ctrl_hit = {i_paddr == `SE_REG_CTRL1, i_paddr == `SE_REG_CTRL0};
    assign busy_eff = i_busy | o_start;
    assign wr_ok    = {2{access & i_pwrite}} & ctrl_hit & ~busy_eff;

    // Buffer window, request held until grant, dropped while read data returns
    assign o_buf_req   = access & is_buf & ~rd_q;
    assign o_buf_we    = i_pwrite;
    assign o_buf_addr  = i_paddr[`SE_ADDR_W+1:2];
    assign o_buf_wdata = i_pwdata[`SE_DATA_W-1:0];

    // Registers answer at once, buffer after arbitration
    assign o_pready  = access & (is_buf ? (i_pwrite ? i_buf_gnt : rd_q) : 1'b1);
    assign o_pslverr = access & i_pwrite & |(ctrl_hit & busy_eff);

    always_comb begin
        o_prdata = '0;
        if (is_buf) begin
            o_prdata[`SE_DATA_W-1:0] = i_buf_rdata;
        end else if (i_paddr == `SE_REG_STATUS) begin
            o_prdata[1:0]             = i_busy;
            o_prdata[8 +: `SE_CNT_W]  = i_ones0;
            o_prdata[16 +: `SE_CNT_W] = i_ones1;
        end
        for (int n = 0; n < 2; n++) begin
            if (ctrl_hit[n]) begin   // CTRL readback, same layout as write
                o_prdata[1:0]              = op_q[n];
                o_prdata[2]                = fill_q[n];
                o_prdata[4 +: `SE_CNT_W]   = count_q[n];
                o_prdata[12 +: `SE_ADDR_W] = addr_q[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_start <= 2'b00;
            rd_q    <= 1'b0;
        end else begin
            o_start <= wr_ok;
            rd_q    <= o_buf_req & i_buf_gnt & ~i_pwrite;
        end
    end

    // Command fields, written only when accepted
    always_ff @(posedge clk) begin
        for (int n = 0; n < 2; n++) begin
            if (wr_ok[n]) begin
                op_q[n]    <= shift_op_e'(i_pwdata[1:0]);
                fill_q[n]  <= i_pwdata[2];
                count_q[n] <= i_pwdata[4 +: `SE_CNT_W];
                addr_q[n]  <= i_pwdata[12 +: `SE_ADDR_W];
            end
        end
    end

    assign o_op0    = op_q[0];
    assign o_fill0  = fill_q[0];
    assign o_count0 = count_q[0];
    assign o_addr0  = addr_q[0];
    assign o_op1    = op_q[1];
    assign o_fill1  = fill_q[1];
    assign o_count1 = count_q[1];
    assign o_addr1  = addr_q[1];

    a_penable_psel: assert property (@(posedge clk) disable iff (i_reset)
        i_penable |-> i_psel);

endmodule

// File: shift_engine_top.sv
// Top of the shift coprocessor: APB slave, two shift channels and the shared buffer
`timescale 1ns/1ps
`include "shift_engine_defines.svh"

module shift_engine_top (
    input  logic        clk,
    input  logic        i_reset,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr
);
    import shift_engine_pkg::*;

    // Buffer clients, index 2 is APB
    logic [2:0]            buf_req;
    logic [2:0]            buf_we;
    logic [2:0]            buf_gnt;
    logic [`SE_ADDR_W-1:0] buf_addr  [3];
    logic [`SE_DATA_W-1:0] buf_wdata [3];
    logic [`SE_DATA_W-1:0] buf_rdata;

    // Per-channel command and status
    logic [1:0]            start;
    logic [1:0]            busy;
    shift_op_e             op    [2];
    logic                  fill  [2];
    logic [`SE_CNT_W-1:0]  count [2];
    logic [`SE_ADDR_W-1:0] addr  [2];
    logic [`SE_CNT_W-1:0]  ones  [2];

    apb_shift_regs u_regs (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .o_start     (start),
        .o_op0       (op[0]),
        .o_fill0     (fill[0]),
        .o_count0    (count[0]),
        .o_addr0     (addr[0]),
        .o_op1       (op[1]),
        .o_fill1     (fill[1]),
        .o_count1    (count[1]),
        .o_addr1     (addr[1]),
        .i_busy      (busy),
        .i_ones0     (ones[0]),
        .i_ones1     (ones[1]),
        .o_buf_req   (buf_req[2]),
        .o_buf_we    (buf_we[2]),
        .o_buf_addr  (buf_addr[2]),
        .o_buf_wdata (buf_wdata[2]),
        .i_buf_gnt   (buf_gnt[2]),
        .i_buf_rdata (buf_rdata)
    );

    shift_channel u_chan0 (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_start     (start[0]),
        .i_op        (op[0]),
        .i_fill      (fill[0]),
        .i_count     (count[0]),
        .i_addr      (addr[0]),
        .o_busy      (busy[0]),
        .o_ones      (ones[0]),
        .o_buf_req   (buf_req[0]),
        .o_buf_we    (buf_we[0]),
        .o_buf_addr  (buf_addr[0]),
        .o_buf_wdata (buf_wdata[0]),
        .i_buf_gnt   (buf_gnt[0]),
        .i_buf_rdata (buf_rdata)
    );

    shift_channel u_chan1 (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_start     (start[1]),
        .i_op        (op[1]),
        .i_fill      (fill[1]),
        .i_count     (count[1]),
        .i_addr      (addr[1]),
        .o_busy      (busy[1]),
        .o_ones      (ones[1]),
        .o_buf_req   (buf_req[1]),
        .o_buf_we    (buf_we[1]),
        .o_buf_addr  (buf_addr[1]),
        .o_buf_wdata (buf_wdata[1]),
        .i_buf_gnt   (buf_gnt[1]),
        .i_buf_rdata (buf_rdata)
    );

    word_buffer_arb u_buf (
        .clk     (clk),
        .i_reset (i_reset),
        .i_req   (buf_req),
        .i_we    (buf_we),
        .i_addr  (buf_addr),
        .i_wdata (buf_wdata),
        .o_gnt   (buf_gnt),
        .o_rdata (buf_rdata)
    );

endmodule

// File: tb_clock_gen.sv
// Free-running testbench clock for the shift coprocessor testbench, 40 ns period by default
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;   // Known level at time zero
    end

    always begin
        #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

// File: tb_shift_engine.sv
// Testbench of the shift coprocessor; drives APB and checks results against a shift model
`timescale 1ns/1ps
`include "shift_engine_defines.svh"

module tb_shift_engine;
    import shift_engine_pkg::*;

    localparam int DW       = `SE_DATA_W;
    localparam int CW       = `SE_CNT_W;
    localparam int N_CMDS   = 24 + 8 + 2 + 8;   // Single, dual, busy, chained
    localparam int WDOG_CYC = N_CMDS * 200;
    localparam int G_BUF    = 0;                // Error groups
    localparam int G_CH0    = 1;
    localparam int G_DUAL   = 2;
    localparam int G_BUSY   = 3;
    localparam int G_CHAIN  = 4;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr_state = 32'hf20d_a968;
    logic [DW-1:0] buf_model [1 << `SE_ADDR_W];   // Expected buffer contents
    int          err_cnt [5];
    int          cur_grp;
    logic [31:0] act_q [$];   // Pending compares
    logic [31:0] exp_q [$];
    string       msg_q [$];
    int          grp_q [$];

    tb_clock_gen #(.PERIOD_NS(40)) u_clk (.o_clk(clk));

    shift_engine_top UUT (
        .clk       (clk),
        .i_reset   (reset),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Expected {ones, word} after count single-bit steps
    function automatic logic [CW+DW-1:0] shift_reference(input shift_op_e op, input logic fill,
                                                         input int count, input logic [DW-1:0] word);
        logic [DW-1:0] w;
        logic          out;
        int            ones;
        w    = word;
        ones = 0;
        for (int k = 0; k < count; k++) begin
            case (op)
                OP_SHL: begin
                    out = w[DW-1];
                    w   = {w[DW-2:0], fill};
                end
                OP_SHR: begin
                    out = w[0];
                    w   = {fill, w[DW-1:1]};
                end
                OP_ROL: begin
                    out = w[DW-1];
                    w   = {w[DW-2:0], w[DW-1]};   // MSB wraps to bit 0
                end
                default: begin
                    out = w[0];
                    w   = {w[0], w[DW-1:1]};
                end
            endcase
            ones = ones + int'(out);   // Rotated-out bits count as well
        end
        return {ones[CW-1:0], w};
    endfunction

    task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                  input string msg, input int grp);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %h expected %h", $time, msg, actual, expected);
            err_cnt[grp]++;
        end
    endtask

    task automatic expect_value(input logic [31:0] actual, input logic [31:0] expected,
                                input string msg);
        act_q.push_back(actual);
        exp_q.push_back(expected);
        msg_q.push_back(msg);
        grp_q.push_back(cur_grp);
    endtask

    // Compare process drains queued results at the falling edge
    always @(negedge clk) begin
        while (exp_q.size() != 0) begin
            compare_values(act_q.pop_front(), exp_q.pop_front(), msg_q.pop_front(),
                           grp_q.pop_front());
        end
    end

    // APB3 transfer through setup and access phases until PREADY
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);   // Wait states while buffer is contended
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_word(input logic [3:0] addr, input logic [DW-1:0] word);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, `SE_BUF_BASE | {2'b00, addr, 2'b00}, {16'h0, word}, rd, err);
        expect_value(err, 0, $sformatf("PSLVERR on buffer write %0d", addr));
        buf_model[addr] = word;
    endtask

    task automatic read_word(input logic [3:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, `SE_BUF_BASE | {2'b00, addr, 2'b00}, 32'h0, data, err);
        expect_value(err, 0, $sformatf("PSLVERR on buffer read %0d", addr));
    endtask

    task automatic send_cmd(input int chan, input shift_op_e op, input logic fill,
                            input int count, input logic [3:0] addr, input logic exp_err);
        logic [31:0] ctrl;
        logic [31:0] rd;
        logic        err;
        ctrl           = '0;
        ctrl[1:0]      = op;
        ctrl[2]        = fill;
        ctrl[4 +: CW]  = count[CW-1:0];
        ctrl[12 +: 4]  = addr;
        apb_xfer(1'b1, (chan != 0) ? `SE_REG_CTRL1 : `SE_REG_CTRL0, ctrl, rd, err);
        expect_value(err, exp_err, $sformatf("PSLVERR on CTRL%0d write", chan));
    endtask

    // Polls STATUS at least once, until the masked busy bits drop
    task automatic wait_idle(input logic [1:0] mask, output logic [31:0] st);
        logic err;
        do begin
            apb_xfer(1'b0, `SE_REG_STATUS, 32'h0, st, err);
        end while ((st[1:0] & mask) != 2'b00);
    endtask

    task automatic check_result(input int chan, input logic [3:0] addr,
                                input logic [CW+DW-1:0] exp, input logic [31:0] st);
        logic [31:0] got;
        read_word(addr, got);
        expect_value(got, exp[DW-1:0], $sformatf("ch%0d word %0d result", chan, addr));
        expect_value((chan != 0) ? st[16 +: CW] : st[8 +: CW], exp[DW +: CW],
                     $sformatf("ch%0d ones count", chan));
        buf_model[addr] = exp[DW-1:0];
    endtask

    // Runs one command on the current model word to completion
    task automatic single_cmd(input int chan, input shift_op_e op, input logic fill,
                              input int count, input logic [3:0] addr);
        logic [CW+DW-1:0] exp;
        logic [31:0]      st;
        exp = shift_reference(op, fill, count, buf_model[addr]);
        send_cmd(chan, op, fill, count, addr, 1'b0);
        wait_idle(2'b11, st);
        check_result(chan, addr, exp, st);
    endtask

    initial begin
        int               cnt;
        int               c0;
        int               c1;
        int               total;
        logic [31:0]      rnd;
        logic [31:0]      st;
        logic [3:0]       a;
        logic [3:0]       b;
        logic [CW+DW-1:0] exp0;
        logic [CW+DW-1:0] exp1;
        shift_op_e        op0;
        shift_op_e        op1;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Buffer round trip and clean STATUS
        cur_grp = G_BUF;
        wait_idle(2'b00, st);
        expect_value(st, 32'h0, "STATUS after reset");
        for (int i = 0; i < 16; i++) begin
            rnd = take_bits(DW);
            write_word(i[3:0], rnd[DW-1:0]);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(i[3:0], rnd);
            expect_value(rnd, {16'h0, buf_model[i]}, $sformatf("buffer readback %0d", i));
        end

        // Every opcode on channel 0 with edge and random counts
        cur_grp = G_CH0;
        for (int o = 0; o < 4; o++) begin
            for (int c = 0; c < 6; c++) begin
                case (c)
                    0:       cnt = 0;
                    1:       cnt = 1;
                    2:       cnt = 15;
                    3:       cnt = 16;
                    default: cnt = take_bits(CW) % 17;
                endcase
                rnd = take_bits(4);
                a   = rnd[3:0];
                rnd = take_bits(DW);
                write_word(a, rnd[DW-1:0]);
                single_cmd(0, shift_op_e'(o), lfsr_bit(), cnt, a);
            end
        end

        // Both channels at once while STATUS is polled
        cur_grp = G_DUAL;
        for (int r = 0; r < 4; r++) begin
            rnd = take_bits(4);
            a   = rnd[3:0];
            rnd = take_bits(4) | 32'd1;   // Nonzero xor keeps addresses apart
            b   = a ^ rnd[3:0];
            rnd = take_bits(4);
            op0 = shift_op_e'(rnd[1:0]);
            op1 = shift_op_e'(rnd[3:2]);
            c0  = take_bits(CW) % 17;
            c1  = take_bits(CW) % 17;
            rnd = take_bits(2);
            exp0 = shift_reference(op0, rnd[0], c0, buf_model[a]);
            exp1 = shift_reference(op1, rnd[1], c1, buf_model[b]);
            send_cmd(0, op0, rnd[0], c0, a, 1'b0);
            send_cmd(1, op1, rnd[1], c1, b, 1'b0);
            wait_idle(2'b11, st);
            check_result(0, a, exp0, st);
            check_result(1, b, exp1, st);
        end

        // Rejected CTRL writes leave running commands alone
        cur_grp = G_BUSY;
        a    = 4'd3;
        b    = 4'd12;
        exp0 = shift_reference(OP_ROL, 1'b0, 16, buf_model[a]);
        exp1 = shift_reference(OP_SHR, 1'b1, 16, buf_model[b]);
        send_cmd(0, OP_ROL, 1'b0, 16, a, 1'b0);
        send_cmd(0, OP_SHL, 1'b1, 3, b, 1'b1);
        send_cmd(1, OP_SHR, 1'b1, 16, b, 1'b0);
        send_cmd(1, OP_ROR, 1'b0, 5, a, 1'b1);
        wait_idle(2'b11, st);
        check_result(0, a, exp0, st);
        check_result(1, b, exp1, st);

        // Second command on the first result
        cur_grp = G_CHAIN;
        for (int r = 0; r < 4; r++) begin
            rnd = take_bits(4);
            a   = rnd[3:0];
            rnd = take_bits(DW);
            write_word(a, rnd[DW-1:0]);
            for (int k = 0; k < 2; k++) begin
                rnd = take_bits(2);
                single_cmd(r % 2, shift_op_e'(rnd[1:0]), lfsr_bit(), take_bits(CW) % 17, a);
            end
        end

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        total = err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] + err_cnt[4];
        $display("Errors: buffer %0d, channel0 %0d, dual %0d, busy %0d, chain %0d, total %0d",
                 err_cnt[G_BUF], err_cnt[G_CH0], err_cnt[G_DUAL], err_cnt[G_BUSY],
                 err_cnt[G_CHAIN], total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog bound scales with the command count
    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a transfer or command never finished",
                 WDOG_CYC);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
shift_engine_pkg.sv
shifter_universal.sv
shift_channel.sv
word_buffer_arb.sv
apb_shift_regs.sv
shift_engine_top.sv
tb_clock_gen.sv
tb_shift_engine.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_shift_engine -f files.f

out=$(./obj_dir/Vtb_shift_engine)
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1
